/* hw/exec_pkg.sv */
// Shared encodings and structs for the execute stage; an all-zero request is a bubble
`default_nettype none

package exec_pkg;

    typedef enum logic [2:0] {
        UNIT_NONE = 3'd0,  // Bubble
        UNIT_ALU  = 3'd1,
        UNIT_MUL  = 3'd2,
        UNIT_CSR  = 3'd3,
        UNIT_LSU  = 3'd4   // Address only, checked for alignment
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS2
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    typedef enum logic [1:0] {
        KIND_OTHER, KIND_BRANCH, KIND_JUMP
    } instr_kind_e;

    typedef enum logic [1:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU
    } mul_op_e;

    typedef enum logic [2:0] {
        CSR_OP_NONE, CSR_OP_RW, CSR_OP_RS, CSR_OP_RC,
        CSR_OP_RWI, CSR_OP_RSI, CSR_OP_RCI, CSR_OP_MRET
    } csr_op_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_RESULT, WB_PC_PLUS4, WB_MUL
    } wb_sel_e;

    typedef struct packed {
        unit_e    unit;
        alu_op_e  alu_op;
        br_cond_e br_cond;
        mul_op_e  mul_op;
        csr_op_e  csr_op;
        wb_sel_e  wb_sel;
    } uop_t;

    // Operand 2 of a CSR instruction
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [14:0] unused;
            logic [4:0]  zimm;
            logic [11:0] addr;
        } fields;
    } csr_operand_u;

    typedef struct packed {
        uop_t        uop;
        logic [4:0]  rd;
        logic [31:1] pc;
        logic [31:1] pc_plus4;
        logic [31:0] op1;       // Forwarded rs1 or pc
        logic [31:0] op2;       // Forwarded rs2 or immediate
        logic        cmp_lt;
        logic        cmp_ltu;
        logic        cmp_eq;
        instr_kind_e kind;
        logic        illegal;
        logic        ecall;
    } ex_req_t;

    typedef struct packed {
        wb_sel_e     wb_sel;
        logic [4:0]  rd;
        logic [31:0] result;
        logic [31:1] pc_plus4;
    } wb_t;

    typedef struct packed {
        logic        valid;
        logic [31:1] target;
    } redirect_t;

    localparam logic [31:0] CAUSE_MISALIGNED_FETCH = 32'd0;
    localparam logic [31:0] CAUSE_ILLEGAL          = 32'd2;
    localparam logic [31:0] CAUSE_MISALIGNED_LOAD  = 32'd4;
    localparam logic [31:0] CAUSE_ECALL_M          = 32'd11;

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

endpackage

`default_nettype wire

/* hw/alu.sv */
// Combinational ALU; set-less-than relies on compare flags from decode, shifts use b[4:0] only
`timescale 1ns/1ps
`default_nettype none

module alu import exec_pkg::*; (
    input  alu_op_e     op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  logic        lt_i,      // Signed a < b from decode
    input  logic        ltu_i,     // Unsigned a < b from decode
    output logic [31:0] result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            ALU_SLT: begin
                result_o = {31'b0, lt_i};   // No second comparator here
            end
            ALU_SLTU: begin
                result_o = {31'b0, ltu_i};
            end
            ALU_PASS2: begin
                result_o = b_i;             // LUI style
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/redirect_unit.sv */
// Branch resolution and trap detection; requests with unit NONE never redirect or trap
`timescale 1ns/1ps
`default_nettype none

module redirect_unit import exec_pkg::*; (
    input  ex_req_t     req_i,
    input  logic [31:0] sum_i,     // Target or address from the ALU
    output logic        taken_o,
    output logic        trap_o,
    output logic [31:0] cause_o
);

    logic active;
    logic cond;
    logic mis_fetch;
    logic mis_lsu;

    assign active = (req_i.uop.unit != UNIT_NONE);

    always_comb begin
        case (req_i.uop.br_cond)
            BR_EQ:   cond = req_i.cmp_eq;
            BR_NE:   cond = !req_i.cmp_eq;
            BR_LT:   cond = req_i.cmp_lt;
            BR_GE:   cond = !req_i.cmp_lt;
            BR_LTU:  cond = req_i.cmp_ltu;
            BR_GEU:  cond = !req_i.cmp_ltu;
            default: cond = 1'b0;  // Stray encodings must not redirect
        endcase
    end

    assign taken_o = active && ((req_i.kind == KIND_JUMP) ||
                                ((req_i.kind == KIND_BRANCH) && cond));

    assign mis_fetch = taken_o && sum_i[0];
    assign mis_lsu   = active && (req_i.uop.unit == UNIT_LSU) && sum_i[0];

    assign trap_o = active && (req_i.illegal || req_i.ecall || mis_fetch || mis_lsu);

    // First match wins
    always_comb begin
        if (req_i.illegal) begin
            cause_o = CAUSE_ILLEGAL;
        end else if (req_i.ecall) begin
            cause_o = CAUSE_ECALL_M;
        end else if (mis_fetch) begin
            cause_o = CAUSE_MISALIGNED_FETCH;
        end else begin
            cause_o = CAUSE_MISALIGNED_LOAD;
        end
    end

endmodule

`default_nettype wire

/* hw/mul_unit.sv */
// Iterative multiplier, MUL_STEP_BITS must divide 32; done pulses in the last busy cycle
`timescale 1ns/1ps
`default_nettype none

module mul_unit import exec_pkg::*; #(
    parameter int MUL_STEP_BITS = 8
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        start_i,
    input  mul_op_e     op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic        busy_o,
    output logic        done_o,
    output logic [31:0] result_o
);

    localparam int STEPS = 32 / MUL_STEP_BITS;
    localparam int CNT_W = $clog2(STEPS) + 1;

    logic             busy_q;
    logic [CNT_W-1:0] count_q;
    logic [63:0]      acc_q;
    logic [63:0]      mcand_q;     // Shifted left every step
    logic [31:0]      mplier_q;    // Shifted right every step
    logic             neg_q;
    logic             hi_q;

    logic        a_neg;
    logic        b_neg;
    logic [31:0] abs_a;
    logic [31:0] abs_b;
    logic        start;
    logic        last;
    logic [63:0] mcand_sel;
    logic [31:0] mplier_sel;
    logic [63:0] partial;
    logic [63:0] product;

    assign a_neg = (op_i != MUL_MULHU) && a_i[31];
    assign b_neg = ((op_i == MUL_MUL) || (op_i == MUL_MULH)) && b_i[31];
    assign abs_a = a_neg ? (~a_i + 32'd1) : a_i;
    assign abs_b = b_neg ? (~b_i + 32'd1) : b_i;

    assign start = start_i && !busy_q;
    assign last  = (count_q == CNT_W'(STEPS));

    // The first step is taken straight from the inputs at start
    assign mcand_sel  = busy_q ? mcand_q : {32'b0, abs_a};
    assign mplier_sel = busy_q ? mplier_q : abs_b;
    assign partial    = mcand_sel * 64'(mplier_sel[MUL_STEP_BITS-1:0]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            count_q <= '0;
        end else if (start) begin
            busy_q  <= 1'b1;
            count_q <= CNT_W'(1);
        end else if (busy_q) begin
            if (last) begin
                busy_q <= 1'b0;
            end else begin
                count_q <= count_q + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            acc_q    <= partial;
            mcand_q  <= {32'b0, abs_a} << MUL_STEP_BITS;
            mplier_q <= abs_b >> MUL_STEP_BITS;
            neg_q    <= a_neg ^ b_neg;
            hi_q     <= (op_i != MUL_MUL);
        end else if (busy_q && !last) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << MUL_STEP_BITS;
            mplier_q <= mplier_q >> MUL_STEP_BITS;
        end
    end

    assign product  = neg_q ? (~acc_q + 64'd1) : acc_q;
    assign result_o = hi_q ? product[63:32] : product[31:0];
    assign busy_o   = busy_q;
    assign done_o   = busy_q && last;

endmodule

`default_nettype wire

/* hw/csr_unit.sv */
// Machine CSRs for an M-only core; mtvec is direct mode only and mstatus keeps just MIE and MPIE
`timescale 1ns/1ps
`default_nettype none

module csr_unit import exec_pkg::*; #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic         clk_i,
    input  logic         rst_i,
    input  csr_op_e      op_i,
    input  csr_operand_u operand_i,
    input  logic [31:0]  src_i,          // rs1 value
    input  logic [31:1]  pc_i,
    input  logic         trap_i,
    input  logic [31:0]  cause_i,
    output logic [31:0]  rdata_o,
    output logic [31:1]  trap_target_o,
    output logic [31:1]  mepc_o
);

    logic        mie_q;
    logic        mpie_q;
    logic [31:2] mtvec_q;
    logic [31:0] mscratch_q;
    logic [31:1] mepc_q;
    logic [31:0] mcause_q;

    logic [11:0] addr;
    logic [31:0] src;
    logic [31:0] wdata;
    logic        we;

    assign addr = operand_i.fields.addr;

    always_comb begin
        case (addr)
            CSR_MSTATUS:  rdata_o = {24'b0, mpie_q, 3'b0, mie_q, 3'b0};
            CSR_MTVEC:    rdata_o = {mtvec_q, 2'b00};
            CSR_MSCRATCH: rdata_o = mscratch_q;
            CSR_MEPC:     rdata_o = {mepc_q, 1'b0};
            CSR_MCAUSE:   rdata_o = mcause_q;
            default:      rdata_o = '0;
        endcase
    end

    // Immediate forms take the zero-extended zimm
    assign src = ((op_i == CSR_OP_RWI) || (op_i == CSR_OP_RSI) || (op_i == CSR_OP_RCI)) ?
                 {27'b0, operand_i.fields.zimm} : src_i;

    always_comb begin
        we = 1'b1;
        case (op_i)
            CSR_OP_RW, CSR_OP_RWI: wdata = src;
            CSR_OP_RS, CSR_OP_RSI: wdata = rdata_o | src;
            CSR_OP_RC, CSR_OP_RCI: wdata = rdata_o & ~src;
            default: begin
                wdata = rdata_o;
                we    = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mie_q      <= 1'b0;
            mpie_q     <= 1'b0;
            mtvec_q    <= MTVEC_RESET[31:2];
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (trap_i) begin
            mepc_q   <= pc_i;
            mcause_q <= cause_i;
            mpie_q   <= mie_q;
            mie_q    <= 1'b0;
        end else if (op_i == CSR_OP_MRET) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (we) begin
            case (addr)
                CSR_MSTATUS: begin
                    mie_q  <= wdata[3];
                    mpie_q <= wdata[7];
                end
                CSR_MTVEC:    mtvec_q    <= wdata[31:2];
                CSR_MSCRATCH: mscratch_q <= wdata;
                CSR_MEPC:     mepc_q     <= wdata[31:1];
                CSR_MCAUSE:   mcause_q   <= wdata;
                default:      ;            // Unknown address drops the write
            endcase
        end
    end

    assign trap_target_o = {mtvec_q, 1'b0};
    assign mepc_o        = mepc_q;

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
// Execute stage top; decode must hold its instruction and send bubbles while ready_o is low
`timescale 1ns/1ps
`default_nettype none

module execute_stage import exec_pkg::*; #(
    parameter int          MUL_STEP_BITS = 8,
    parameter logic [31:0] MTVEC_RESET   = 32'h0000_0100
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  ex_req_t     req_i,
    output logic        ready_o,
    output redirect_t   redirect_o,
    output logic [31:0] fwd_value_o,
    output wb_t         wb_o
);

    ex_req_t      req_g;
    alu_op_e      alu_op;
    logic [31:0]  alu_res;
    logic         taken;
    logic         trap;
    logic [31:0]  cause;
    csr_op_e      csr_op;
    csr_operand_u csr_operand;
    logic [31:0]  csr_rdata;
    logic [31:1]  trap_target;
    logic [31:1]  mepc;
    logic         is_mret;
    logic         mul_start;
    logic         mul_busy;
    logic         mul_done;
    logic [31:0]  mul_res;
    logic [31:0]  unit_res;
    wb_sel_e      req_wb_sel;

    logic [4:0]   pend_rd_q;       // Destination of the running multiply
    logic [31:1]  pend_pc4_q;
    wb_sel_e      wb_sel_q;
    logic [4:0]   wb_rd_q;
    logic [31:0]  wb_result_q;
    logic [31:1]  wb_pc4_q;

    // Requests are dropped to bubbles while the multiplier runs
    always_comb begin
        req_g = req_i;
        if (mul_busy) begin
            req_g.uop.unit = UNIT_NONE;
        end
    end

    // Targets and memory addresses always add
    assign alu_op = ((req_g.kind != KIND_OTHER) || (req_g.uop.unit == UNIT_LSU)) ?
                    ALU_ADD : req_g.uop.alu_op;

    alu u_alu (
        .op_i     (alu_op),
        .a_i      (req_g.op1),
        .b_i      (req_g.op2),
        .lt_i     (req_g.cmp_lt),
        .ltu_i    (req_g.cmp_ltu),
        .result_o (alu_res)
    );

    redirect_unit u_redirect (
        .req_i   (req_g),
        .sum_i   (alu_res),
        .taken_o (taken),
        .trap_o  (trap),
        .cause_o (cause)
    );

    assign csr_op           = (req_g.uop.unit == UNIT_CSR) ? req_g.uop.csr_op : CSR_OP_NONE;
    assign csr_operand.word = req_g.op2;

    csr_unit #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .op_i          (csr_op),
        .operand_i     (csr_operand),
        .src_i         (req_g.op1),
        .pc_i          (req_g.pc),
        .trap_i        (trap),
        .cause_i       (cause),
        .rdata_o       (csr_rdata),
        .trap_target_o (trap_target),
        .mepc_o        (mepc)
    );

    assign mul_start = (req_g.uop.unit == UNIT_MUL) && !trap;

    mul_unit #(
        .MUL_STEP_BITS (MUL_STEP_BITS)
    ) u_mul (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (mul_start),
        .op_i     (req_g.uop.mul_op),
        .a_i      (req_g.op1),
        .b_i      (req_g.op2),
        .busy_o   (mul_busy),
        .done_o   (mul_done),
        .result_o (mul_res)
    );

    always_comb begin
        case (req_g.uop.unit)
            UNIT_ALU, UNIT_LSU: unit_res = alu_res;
            UNIT_CSR:           unit_res = csr_rdata;
            default:            unit_res = '0;   // Product comes later
        endcase
    end

    assign fwd_value_o = (req_g.uop.wb_sel == WB_PC_PLUS4) ? {req_g.pc_plus4, 1'b0} : unit_res;

    assign is_mret           = (csr_op == CSR_OP_MRET) && !trap;
    assign redirect_o.valid  = trap || is_mret || taken;
    assign redirect_o.target = trap ? trap_target : (is_mret ? mepc : alu_res[31:1]);

    // Traps, bubbles and multiply issue write nothing now
    assign req_wb_sel = (trap || (req_g.uop.unit == UNIT_NONE) ||
                         (req_g.uop.unit == UNIT_MUL)) ? WB_NONE : req_g.uop.wb_sel;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_sel_q <= WB_NONE;
        end else begin
            wb_sel_q <= mul_done ? WB_MUL : req_wb_sel;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_start) begin
            pend_rd_q  <= req_g.rd;
            pend_pc4_q <= req_g.pc_plus4;
        end
        wb_rd_q     <= mul_done ? pend_rd_q : req_g.rd;
        wb_result_q <= mul_done ? mul_res : unit_res;
        wb_pc4_q    <= mul_done ? pend_pc4_q : req_g.pc_plus4;
    end

    assign wb_o.wb_sel   = wb_sel_q;
    assign wb_o.rd       = wb_rd_q;
    assign wb_o.result   = wb_result_q;
    assign wb_o.pc_plus4 = wb_pc4_q;
    assign ready_o       = !mul_busy;

endmodule

`default_nettype wire

/* tests/tb_checks.svh */
// Reference models and checks, included inside the testbench module and using its signals
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_true(input string what, input logic cond);
    check_count++;
    assert (cond) else begin
        value_errors++;
        $display("[FAIL] %0t: %s", $time, what);
    end
endtask

task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got == exp) else begin
        value_errors++;
        $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [4:0]  s;
    logic [31:0] r;
    s = b[4:0];
    case (op)
        ALU_ADD:   r = a + b;
        ALU_SUB:   r = a + ~b + 32'd1;
        ALU_AND:   r = a & b;
        ALU_OR:    r = a | b;
        ALU_XOR:   r = a ^ b;
        ALU_SLL:   r = a << s;
        ALU_SRL:   r = a >> s;
        ALU_SRA:   r = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'd0);  // Fill with sign
        ALU_SLT:   r = {31'b0, ($signed(a) < $signed(b))};
        ALU_SLTU:  r = {31'b0, (a < b)};
        ALU_PASS2: r = b;
        default:   r = 32'd0;
    endcase
    return r;
endfunction

function automatic logic taken_model(input ex_req_t r);
    logic c;
    case (r.uop.br_cond)
        BR_EQ:   c = r.cmp_eq;
        BR_NE:   c = ~r.cmp_eq;
        BR_LT:   c = r.cmp_lt;
        BR_GE:   c = ~r.cmp_lt;
        BR_LTU:  c = r.cmp_ltu;
        BR_GEU:  c = ~r.cmp_ltu;
        default: c = 1'b0;       // NONE and the spare code
    endcase
    return (r.kind == KIND_JUMP) || ((r.kind == KIND_BRANCH) && c);
endfunction

// Extended operands multiplied modulo 2**64 give the signed forms as well
function automatic logic [31:0] mul_model(input mul_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] p;
    case (op)
        MUL_MULH:   p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        MUL_MULHSU: p = {{32{a[31]}}, a} * {32'b0, b};
        default:    p = {32'b0, a} * {32'b0, b};
    endcase
    return (op == MUL_MUL) ? p[31:0] : p[63:32];
endfunction

function automatic logic [31:0] csr_model(input csr_op_e op, input logic [31:0] old,
                                          input logic [31:0] rs1, input logic [4:0] zimm);
    logic [31:0] s;
    logic [31:0] r;
    s = (op == CSR_OP_RWI || op == CSR_OP_RSI || op == CSR_OP_RCI) ? {27'b0, zimm} : rs1;
    case (op)
        CSR_OP_RW, CSR_OP_RWI: r = s;
        CSR_OP_RS, CSR_OP_RSI: r = old | s;
        CSR_OP_RC, CSR_OP_RCI: r = old & ~s;
        default:               r = old;
    endcase
    return r;
endfunction

bubble_no_redirect: assert property (@(posedge clk) disable iff (rst)
    !((req.uop.unit == UNIT_NONE) && redirect.valid))
    else begin
        protocol_errors++;
        $display("[FAIL] %0t: bubble raised a redirect", $time);
    end

product_after_busy: assert property (@(posedge clk) disable iff (rst)
    !((wb.wb_sel == WB_MUL) && !ready))
    else begin
        protocol_errors++;
        $display("[FAIL] %0t: product written while ready is low", $time);
    end

`endif

/* tests/tb_execute_stage.sv */
// Testbench for the execute stage; assumes MUL_STEP_BITS 8 and an mtvec reset value of 0x100
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage import exec_pkg::*; ();

    localparam int          STEP_BITS  = 8;
    localparam logic [31:0] MTVEC_INIT = 32'h0000_0100;
    localparam int          CLK_PERIOD = 4;
    localparam int          MAX_REQS   = 400;

    logic        clk;
    logic        rst;
    ex_req_t     req;
    logic        ready;
    redirect_t   redirect;
    logic [31:0] fwd_value;
    wb_t         wb;

    int value_errors;
    int protocol_errors;
    int check_count;

    `include "tb_checks.svh"

    execute_stage #(
        .MUL_STEP_BITS (STEP_BITS),
        .MTVEC_RESET   (MTVEC_INIT)
    ) DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_i       (req),
        .ready_o     (ready),
        .redirect_o  (redirect),
        .fwd_value_o (fwd_value),
        .wb_o        (wb)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic ex_req_t idle_req();
        ex_req_t r;
        r = '0;
        return r;
    endfunction

    // Compare flags as decode would produce them
    function automatic ex_req_t with_flags(input ex_req_t r);
        ex_req_t f;
        f = r;
        f.cmp_eq  = (r.op1 == r.op2);
        f.cmp_lt  = ($signed(r.op1) < $signed(r.op2));
        f.cmp_ltu = (r.op1 < r.op2);
        return f;
    endfunction

    function automatic ex_req_t misaligned_req(input unit_e unit, input instr_kind_e kind);
        ex_req_t r;
        r = '0;
        r.uop.unit   = unit;
        r.uop.wb_sel = (kind == KIND_JUMP) ? WB_PC_PLUS4 : WB_RESULT;
        r.kind       = kind;
        r.rd         = 5'($urandom);
        r.pc         = 31'($urandom);
        r.pc_plus4   = r.pc + 31'd2;
        r.op1        = {r.pc, 1'b0};
        r.op2        = $urandom | 32'd1;   // Odd sum
        return r;
    endfunction

    task automatic step(input ex_req_t r);
        @(negedge clk);
        req = r;
        #1;                                 // Let the combinational outputs settle
    endtask

    task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] rs1, input logic [4:0] zimm,
                              input logic [31:0] exp_old);
        ex_req_t r;
        r = '0;
        r.uop.unit   = UNIT_CSR;
        r.uop.csr_op = op;
        r.uop.wb_sel = WB_RESULT;
        r.rd         = 5'($urandom);
        r.op1        = rs1;
        r.op2        = {15'($urandom), zimm, addr};
        step(r);
        check_eq("CSR read forward", fwd_value, exp_old);
        step(idle_req());
        check_eq("CSR read writeback", wb.result, exp_old);
        check_true("CSR writeback select and rd", wb.wb_sel == WB_RESULT && wb.rd == r.rd);
    endtask

    task automatic trap_case(input ex_req_t r, input logic [31:0] cause);
        ex_req_t m;
        step(r);
        check_true("trap raises a redirect", redirect.valid);
        check_eq("trap target", {redirect.target, 1'b0}, {MTVEC_INIT[31:1], 1'b0});
        step(idle_req());
        check_true("trap suppresses writeback", wb.wb_sel == WB_NONE);
        csr_access(CSR_OP_RS, CSR_MCAUSE, 32'd0, 5'd0, cause);
        csr_access(CSR_OP_RS, CSR_MEPC, 32'd0, 5'd0, {r.pc, 1'b0});
        m = idle_req();
        m.uop.unit   = UNIT_CSR;
        m.uop.csr_op = CSR_OP_MRET;
        step(m);
        check_true("mret raises a redirect", redirect.valid);
        check_eq("mret target", {redirect.target, 1'b0}, {r.pc, 1'b0});
    endtask

    initial begin
        ex_req_t     r;
        ex_req_t     junk;
        logic [31:0] exp;
        logic [31:0] sum;
        logic [31:0] scratch;
        logic [31:0] src;
        logic [4:0]  zimm;
        csr_op_e     op;
        logic        exp_taken;
        int          low_cycles;

        value_errors    = 0;
        protocol_errors = 0;
        check_count     = 0;
        void'($urandom(13));
        rst = 1'b1;
        req = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_true("ready after reset", ready);
        check_true("no redirect after reset", !redirect.valid);
        check_true("no writeback after reset", wb.wb_sel == WB_NONE);

        for (int i = 0; i < 100; i++) begin
            r = idle_req();
            r.uop.unit   = UNIT_ALU;
            r.uop.alu_op = alu_op_e'(4'($urandom % 11));
            r.uop.wb_sel = WB_RESULT;
            r.rd         = 5'($urandom);
            r.op1        = $urandom;
            r.op2        = (i % 5 == 0) ? r.op1 : $urandom;
            r            = with_flags(r);
            exp          = alu_model(r.uop.alu_op, r.op1, r.op2);
            step(r);
            check_eq("ALU forward", fwd_value, exp);
            step(idle_req());
            check_eq("ALU writeback", wb.result, exp);
            check_true("ALU writeback select and rd", wb.wb_sel == WB_RESULT && wb.rd == r.rd);
        end

        for (int i = 0; i < 60; i++) begin
            r = idle_req();
            r.uop.unit    = UNIT_ALU;
            r.kind        = (i % 4 == 0) ? KIND_JUMP : KIND_BRANCH;
            r.uop.br_cond = br_cond_e'(3'($urandom));
            r.uop.wb_sel  = (r.kind == KIND_JUMP) ? WB_PC_PLUS4 : WB_NONE;
            {r.cmp_eq, r.cmp_lt, r.cmp_ltu} = 3'($urandom);
            r.pc          = 31'($urandom);
            r.pc_plus4    = r.pc + 31'd2;
            r.op1         = $urandom & ~32'd1;
            r.op2         = $urandom & ~32'd1;  // Even target
            sum           = r.op1 + r.op2;
            exp_taken     = taken_model(r);
            step(r);
            check_true("redirect follows the condition", redirect.valid == exp_taken);
            if (exp_taken) begin
                check_eq("branch target", {redirect.target, 1'b0}, sum);
            end
            if (r.kind == KIND_JUMP) begin
                check_eq("jump link forward", fwd_value, {r.pc_plus4, 1'b0});
            end
            junk = idle_req();
            junk.kind    = instr_kind_e'(2'($urandom));
            junk.illegal = 1'($urandom);
            junk.ecall   = 1'($urandom);
            junk.cmp_eq  = 1'b1;
            step(junk);
            check_true("bubble does not redirect", !redirect.valid);
            check_true("branch or jump writeback",
                       wb.wb_sel == r.uop.wb_sel &&
                       (r.kind != KIND_JUMP || wb.pc_plus4 == r.pc_plus4));
        end

        trap_case(misaligned_req(UNIT_ALU, KIND_JUMP), CAUSE_MISALIGNED_FETCH);
        r = misaligned_req(UNIT_ALU, KIND_BRANCH);
        r.uop.br_cond = BR_EQ;
        r.cmp_eq      = 1'b1;
        trap_case(r, CAUSE_MISALIGNED_FETCH);
        trap_case(misaligned_req(UNIT_LSU, KIND_OTHER), CAUSE_MISALIGNED_LOAD);
        r = misaligned_req(UNIT_ALU, KIND_OTHER);
        r.illegal = 1'b1;
        trap_case(r, CAUSE_ILLEGAL);
        r = misaligned_req(UNIT_ALU, KIND_OTHER);
        r.ecall = 1'b1;
        trap_case(r, CAUSE_ECALL_M);
        r = misaligned_req(UNIT_ALU, KIND_JUMP);
        r.illegal = 1'b1;
        r.ecall   = 1'b1;
        trap_case(r, CAUSE_ILLEGAL);                 // Illegal beats ecall
        r = misaligned_req(UNIT_ALU, KIND_JUMP);
        r.ecall = 1'b1;
        trap_case(r, CAUSE_ECALL_M);

        scratch = 32'd0;
        for (int i = 0; i < 12; i++) begin
            op   = csr_op_e'(3'(1 + i % 6));
            src  = $urandom;
            zimm = 5'($urandom);
            csr_access(op, CSR_MSCRATCH, src, zimm, scratch);
            scratch = csr_model(op, scratch, src, zimm);
        end
        csr_access(CSR_OP_RS, CSR_MSCRATCH, 32'd0, 5'd0, scratch);
        csr_access(CSR_OP_RW, 12'h7c0, $urandom, 5'd0, 32'd0);
        csr_access(CSR_OP_RS, 12'h7c0, 32'd0, 5'd0, 32'd0);

        for (int i = 0; i < 40; i++) begin
            r = idle_req();
            r.uop.unit   = UNIT_MUL;
            r.uop.mul_op = mul_op_e'(2'(i));
            r.uop.wb_sel = WB_MUL;
            r.rd         = 5'($urandom);
            r.op1        = (i % 8 == 7) ? 32'h8000_0000 : $urandom;
            r.op2        = $urandom;
            exp          = mul_model(r.uop.mul_op, r.op1, r.op2);
            step(r);
            check_true("ready at multiply issue", ready);
            low_cycles = 0;
            @(negedge clk);
            while (!ready && low_cycles < 64) begin
                check_true("no writeback while busy", wb.wb_sel == WB_NONE);
                junk = r;
                junk.uop.unit   = UNIT_ALU;
                junk.uop.wb_sel = WB_RESULT;
                junk.kind       = KIND_JUMP;      // Would redirect if accepted
                junk.rd         = ~r.rd;          // Other rd and operand than the multiply
                junk.op1        = ~r.op1;
                junk            = with_flags(junk);
                req = junk;
                #1;
                check_true("ignored request does not redirect", !redirect.valid);
                low_cycles++;
                @(negedge clk);
            end
            req = idle_req();
            check_eq("multiply busy cycles", 32'(low_cycles), 32'(32 / STEP_BITS));
            check_eq("multiply product", wb.result, exp);
            check_true("multiply writeback select and rd", wb.wb_sel == WB_MUL && wb.rd == r.rd);
        end

        step(idle_req());
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 check_count, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ten cycles per request is far more than any test sequence needs
    initial begin
        #(MAX_REQS * 10 * CLK_PERIOD);
        $display("Watchdog: the run timed out before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+tests
hw/exec_pkg.sv
hw/alu.sv
hw/redirect_unit.sv
hw/mul_unit.sv
hw/csr_unit.sv
hw/execute_stage.sv
tests/tb_execute_stage.sv

/* Makefile */
TOP = tb_execute_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
